/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - target: any(rtl, test)
    files:
      - sdram_pkg.sv
      - sdram_refresh_timer.sv
      - sdram_timing.sv
      - sdram_cmd_seq.sv
      - sdram_data_path.sv
      - sdram_ctrl_top.sv
  - target: test
    files:
      - tb_sdram_model.sv
      - tb_sdram_ctrl.sv

/* sdram_cmd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_seq import sdram_pkg::*; #(
	parameter int ACTV_HOLD = 4
) (
	input  wire       CLK,
	input  wire       RST,
	input  var addr_t address_req,
	input  wire       we,
	input  wire       do_act,
	input  wire       change_possible,
	input  wire       some_page_active,
	input  wire       refresh_time,
	output cmd_t      command,
	output logic      change_requested,
	output logic      command_latched,
	output cmd_t      cmd,
	output pin_addr_t pin_addr,
	output bank_t     bank
);

	localparam int HOLD_W = $clog2(ACTV_HOLD + 1);

	row_t  req_row;
	bank_t req_bank;
	col_t  req_col;
	page_t page_current;    // row and bank of the open page
	cmd_t  command_buf;     // next step when there is no page hit
	cmd_t  rw_command;
	logic  page_hit;
	logic  step_req;
	logic  rw_last;         // read or write latched last cycle
	logic  refresh_time_q;
	logic  hold_done;
	logic [HOLD_W-1:0] open_cnt;  // cycles since the page opened

	assign req_row  = address_req[25:14];
	assign req_bank = address_req[13:12];
	assign req_col  = address_req[11:0];

	assign rw_command = we ? WRTE : READ;
	assign page_hit = some_page_active && !refresh_time &&
		({req_row, req_bank} == page_current);
	// command_buf lags by a cycle, so a fresh refresh waits for it
	assign step_req = (do_act && !refresh_time) || refresh_time_q;
	assign hold_done = (open_cnt == HOLD_W'(ACTV_HOLD));

	assign command = page_hit ? rw_command : command_buf;
	assign change_requested = page_hit ? (do_act && !rw_last) : step_req;
	assign command_latched = page_hit && do_act && !rw_last && change_possible;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			cmd <= NOOP;
			pin_addr <= PIN_ADDR_ALL_BANKS;
			bank <= '0;
			page_current <= '0;
			command_buf <= PRCH;
			open_cnt <= '0;
			rw_last <= 1'b0;
			refresh_time_q <= 1'b0;
		end
		else
		begin
			refresh_time_q <= refresh_time;
			rw_last <= command_latched;  // keeps two beats between accesses

			if (!some_page_active)
				open_cnt <= '0;
			else if (!hold_done)
				open_cnt <= open_cnt + 1'b1;

			if (some_page_active)
				command_buf <= hold_done ? PRCH : NOOP;
			else if (refresh_time)
				command_buf <= ARSR;
			else
				command_buf <= ACTV;

			if (page_hit)
			begin
				if (command_latched)
				begin
					cmd <= rw_command;
					pin_addr <= col_pins(req_col);
					bank <= req_bank;
				end
				else
					cmd <= NOOP;
			end
			else
			begin
				cmd <= (change_possible && step_req) ? command_buf : NOOP;
				if (some_page_active)
					pin_addr <= PIN_ADDR_ALL_BANKS;  // precharge all banks
				else
				begin
					page_current <= {req_row, req_bank};
					pin_addr <= row_pins(req_row);
					bank <= req_bank;
				end
			end
		end
	end

	// a pending request stays up and unchanged until it is latched
	a_request_held: assert property (@(posedge CLK) disable iff (!RST)
		(do_act && !command_latched) |=> (do_act && $stable(address_req) && $stable(we)))
		else $error("request dropped or changed before command_latched");

endmodule

`default_nettype wire

/* sdram_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top import sdram_pkg::*; #(
	parameter int REFRESH_PERIOD = 390,
	parameter int ACTV_HOLD = 4,
	parameter int CAS_LATENCY = 2
) (
	input  wire        CLK,
	input  wire        RST,
	input  var addr_t  address_req,
	input  wire        we,
	input  wire        do_act,
	input  var word_t  data_w,
	output logic       command_latched,
	output word_t      data_r,
	output logic       data_r_valid,
	output cmd_t       cmd,
	output pin_addr_t  pin_addr,
	output bank_t      bank,
	inout  wire beat_t dq,
	output logic       dm,
	output logic       dqs
);

	logic refresh_strobe;
	logic change_possible;
	logic change_requested;
	logic some_page_active;
	logic refresh_time;
	cmd_t command;        // step offered by the sequencer

	sdram_refresh_timer #(
		.REFRESH_PERIOD(REFRESH_PERIOD)
	) refresh0 (.*);

	sdram_timing timing0 (
		.*,
		.state()   // last granted command, internal to the tracker
	);

	sdram_cmd_seq #(
		.ACTV_HOLD(ACTV_HOLD)
	) seq0 (.*);

	// write data follows the registered cmd, one cycle after command_latched
	sdram_data_path #(
		.CAS_LATENCY(CAS_LATENCY)
	) data0 (.*);

endmodule

`default_nettype wire

/* sdram_data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_data_path import sdram_pkg::*; #(
	parameter int CAS_LATENCY = 2
) (
	input  wire        CLK,
	input  wire        RST,
	input  var cmd_t   cmd,
	input  var word_t  data_w,
	inout  wire beat_t dq,
	output logic       dm,
	output logic       dqs,
	output word_t      data_r,
	output logic       data_r_valid
);

	word_t data_w_q;    // client word from the latch cycle
	beat_t dq_out;
	beat_t wr_lo;       // second write beat waiting
	beat_t rd_hi;       // first read beat
	logic  wr_drive;    // dq driven this cycle
	logic  wr_second;
	logic [CAS_LATENCY+1:0] rd_pipe;  // one bit per read in flight

	assign dq = wr_drive ? dq_out : 'z;
	assign dm = !wr_drive;       // masked whenever dq is released
	assign dqs = wr_drive;
	assign data_r_valid = rd_pipe[CAS_LATENCY+1];

	// WRTE shows on cmd one cycle after the latch, data_w_q still
	// holds the word the client presented with it
	always_ff @(posedge CLK)
	begin
		data_w_q <= data_w;
		if (cmd == WRTE)
		begin
			dq_out <= data_w_q[31:16];  // high half first
			wr_lo <= data_w_q[15:0];
		end
		else if (wr_second)
			dq_out <= wr_lo;

		if (rd_pipe[CAS_LATENCY-1])
			rd_hi <= dq;               // beat at CAS_LATENCY
		if (rd_pipe[CAS_LATENCY])
			data_r <= {rd_hi, dq};     // beat at CAS_LATENCY+1
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_drive <= 1'b0;
			wr_second <= 1'b0;
			rd_pipe <= '0;
		end
		else
		begin
			wr_drive <= (cmd == WRTE) || wr_second;
			wr_second <= (cmd == WRTE);
			rd_pipe <= {rd_pipe[CAS_LATENCY:0], cmd == READ};
		end
	end

	// command spacing in the sequencer keeps writes off the read beats
	a_no_drive_on_read: assert property (@(posedge CLK) disable iff (!RST)
		(rd_pipe[CAS_LATENCY-1] || rd_pipe[CAS_LATENCY]) |-> !wr_drive)
		else $error("dq driven while a read beat is expected");

endmodule

`default_nettype wire

/* sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

	// command codes on the cmd pins
	typedef enum logic [2:0]
	{
		NOOP = 3'd0,
		ACTV = 3'd1,
		READ = 3'd2,
		WRTE = 3'd3,
		PRCH = 3'd4,
		ARSR = 3'd5
	} cmd_t;

	typedef logic [25:0] addr_t;      // client word address
	typedef logic [11:0] row_t;
	typedef logic [1:0]  bank_t;
	typedef logic [11:0] col_t;
	typedef logic [12:0] pin_addr_t;  // device address pins
	typedef logic [13:0] page_t;      // {row, bank} of the open page
	typedef logic [31:0] word_t;      // client data word
	typedef logic [15:0] beat_t;      // one dq beat

	localparam pin_addr_t PIN_ADDR_ALL_BANKS = 13'h0400;  // a10 high, precharge all

	// row on the pins, a10 kept low so no auto-precharge
	function automatic pin_addr_t row_pins(input row_t row);
		return {row[11:10], 1'b0, row[9:0]};
	endfunction

	function automatic pin_addr_t col_pins(input col_t col);
		return {col, 1'b0};  // word column, trailing zero
	endfunction

endpackage

`default_nettype wire

/* sdram_refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer #(
	parameter int REFRESH_PERIOD = 390
) (
	input  wire  CLK,
	input  wire  RST,
	output logic refresh_strobe
);

	localparam int CNT_W = $clog2(REFRESH_PERIOD);

	logic [CNT_W-1:0] count;  // cycles left in this period

	// the strobe is a level toggle, the timing block compares it
	// with its own acknowledge bit, so a request waits until served
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			count <= CNT_W'(REFRESH_PERIOD - 1);
			refresh_strobe <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= CNT_W'(REFRESH_PERIOD - 1);  // reload
			refresh_strobe <= ~refresh_strobe;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* sdram_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_timing import sdram_pkg::*; (
	input  wire      CLK,
	input  wire      RST,
	input  wire      change_requested,
	input  var cmd_t command,
	input  wire      refresh_strobe,
	output logic     change_possible,
	output cmd_t     state,
	output logic     some_page_active,
	output logic     refresh_time
);

	logic [3:0] counter;       // counts up from the reload value
	logic [3:0] expiry;
	logic       counter_done;  // spacing since last command has elapsed
	logic       state_is_rw;
	logic       miss_beat;     // write recovery still owed before PRCH
	logic       refresh_ack;
	logic       grant;

	// reload value sets the gap to the next different command, 16 - value
	function automatic logic [3:0] reload(input cmd_t c);
		case (c)
			ARSR: return 4'h3;     // 13 cycles
			ACTV: return 4'hc;     // 4 cycles
			READ: return 4'hc;
			WRTE: return 4'hb;     // 5 cycles
			default: return 4'hb;  // PRCH
		endcase
	endfunction

	assign change_possible = counter_done || (state_is_rw && (command == state));
	assign refresh_time = refresh_ack ^ refresh_strobe;
	assign grant = change_possible && change_requested && (command != NOOP);
	assign expiry = {3'b111, miss_beat && (command == PRCH)};  // one extra beat after a write

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			counter <= 4'hc;
			counter_done <= 1'b0;
			state <= PRCH;
			state_is_rw <= 1'b0;
			some_page_active <= 1'b0;
			miss_beat <= 1'b0;
			refresh_ack <= refresh_strobe;
		end
		else if (grant)
		begin
			counter <= reload(command);
			counter_done <= 1'b0;
			state <= command;
			state_is_rw <= (command == READ) || (command == WRTE);
			if (command == ACTV)
				some_page_active <= 1'b1;
			if (command == PRCH)
				some_page_active <= 1'b0;
			if (command == WRTE)
				miss_beat <= 1'b1;
			if (command == ARSR)
				refresh_ack <= refresh_strobe;  // refresh served
		end
		else if (!counter_done)
		begin
			counter <= counter + 1'b1;
			if (counter >= expiry)
			begin
				counter_done <= 1'b1;
				miss_beat <= 1'b0;
			end
		end
	end

	a_state_legal: assert property (@(posedge CLK) disable iff (!RST)
		state inside {ACTV, READ, WRTE, PRCH, ARSR})
		else $error("timing state holds an illegal command code");

	// the sequencer must only open a row or refresh with all banks closed
	a_closed_for_actv: assert property (@(posedge CLK) disable iff (!RST)
		(grant && (command inside {ACTV, ARSR})) |-> !some_page_active)
		else $error("ACTV or ARSR granted while a page is open");

endmodule

`default_nettype wire

/* sim.f */
sdram_pkg.sv
sdram_refresh_timer.sv
sdram_timing.sv
sdram_cmd_seq.sv
sdram_data_path.sv
sdram_ctrl_top.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

/* tb_sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl import sdram_pkg::*; ();

	localparam int REFRESH_PERIOD = 150;  // short, so refresh lands between requests
	localparam int ACTV_HOLD = 4;
	localparam int CAS_LATENCY = 2;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_ENTRIES = 21;
	localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40 + 10 * REFRESH_PERIOD;
	localparam int REFRESH_LIMIT = REFRESH_PERIOD + 40;
	localparam int KIND_FIRST = 0;
	localparam int KIND_HIT = 1;   // same row, no ACTV expected
	localparam int KIND_MISS = 2;  // PRCH and ACTV expected

	logic      CLK;
	logic      RST;
	addr_t     address_req;
	logic      we;
	logic      do_act;
	word_t     data_w;
	logic      command_latched;
	word_t     data_r;
	logic      data_r_valid;
	cmd_t      cmd;
	pin_addr_t pin_addr;
	bank_t     bank;
	wire beat_t dq;
	logic      dm;
	logic      dqs;
	int        model_errors;
	int        errors = 0;

	string t_name [NUM_ENTRIES];
	addr_t t_addr [NUM_ENTRIES];
	logic  t_we [NUM_ENTRIES];
	word_t t_data [NUM_ENTRIES];
	int    t_kind [NUM_ENTRIES];

	word_t shadow [addr_t];  // what the device should hold
	word_t exp_q [$];        // reads in flight in request order
	string exp_name [$];
	int    n_actv = 0;
	int    n_prch = 0;
	int    n_arsr = 0;
	int    since_arsr = 0;
	int    snap_actv = 0;    // counts at the previous latch
	int    snap_prch = 0;
	int    snap_arsr = 0;

	sdram_ctrl_top #(
		.REFRESH_PERIOD(REFRESH_PERIOD),
		.ACTV_HOLD(ACTV_HOLD),
		.CAS_LATENCY(CAS_LATENCY)
	) dut0 (.*);

	tb_sdram_model #(
		.CAS_LATENCY(CAS_LATENCY)
	) model0 (.*, .errors(model_errors));

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s at %0t", what, $time);
		errors++;
	endtask

	task automatic set_entry(input int i, input string name, input row_t r, input bank_t b,
		input col_t c, input logic w, input word_t d, input int kind);
		t_name[i] = name;
		t_addr[i] = {r, b, c};
		t_we[i] = w;
		t_data[i] = d;
		t_kind[i] = kind;
	endtask

	task automatic fill_table();
		set_entry(0, "wr_first", 12'h005, 2'd1, 12'h010, 1'b1, 32'h1234_5678, KIND_FIRST);
		set_entry(1, "rd_hit", 12'h005, 2'd1, 12'h010, 1'b0, '0, KIND_HIT);
		set_entry(2, "wr_hit_col", 12'h005, 2'd1, 12'h011, 1'b1, $urandom(), KIND_HIT);
		set_entry(3, "rd_hit_col", 12'h005, 2'd1, 12'h011, 1'b0, '0, KIND_HIT);
		set_entry(4, "wr_row_miss", 12'h009, 2'd1, 12'h010, 1'b1, $urandom(), KIND_MISS);
		set_entry(5, "rd_row_back", 12'h005, 2'd1, 12'h010, 1'b0, '0, KIND_MISS);
		set_entry(6, "wr_bank2", 12'h009, 2'd2, 12'h3ff, 1'b1, $urandom(), KIND_MISS);
		set_entry(7, "wr_bank2_b", 12'h009, 2'd2, 12'h400, 1'b1, 32'hdead_beef, KIND_HIT);
		set_entry(8, "rd_bank2", 12'h009, 2'd2, 12'h3ff, 1'b0, '0, KIND_HIT);
		set_entry(9, "rd_bank2_b", 12'h009, 2'd2, 12'h400, 1'b0, '0, KIND_HIT);
		set_entry(10, "rd_other_row", 12'h009, 2'd1, 12'h010, 1'b0, '0, KIND_MISS);
		set_entry(11, "wr_row_a10", 12'h400, 2'd0, 12'h005, 1'b1, $urandom(), KIND_MISS);
		set_entry(12, "wr_row_low", 12'h000, 2'd0, 12'h005, 1'b1, $urandom(), KIND_MISS);
		set_entry(13, "rd_row_a10", 12'h400, 2'd0, 12'h005, 1'b0, '0, KIND_MISS);
		set_entry(14, "rd_b2b_0", 12'h005, 2'd1, 12'h010, 1'b0, '0, KIND_MISS);
		set_entry(15, "rd_b2b_1", 12'h005, 2'd1, 12'h011, 1'b0, '0, KIND_HIT);
		set_entry(16, "wr_over", 12'h005, 2'd1, 12'h010, 1'b1, $urandom(), KIND_HIT);
		set_entry(17, "rd_over", 12'h005, 2'd1, 12'h010, 1'b0, '0, KIND_HIT);
		set_entry(18, "wr_top", 12'hfff, 2'd3, 12'hfff, 1'b1, $urandom(), KIND_MISS);
		set_entry(19, "rd_top", 12'hfff, 2'd3, 12'hfff, 1'b0, '0, KIND_HIT);
		set_entry(20, "rd_final", 12'h009, 2'd2, 12'h400, 1'b0, '0, KIND_MISS);
	endtask

	// do_act stays high from one entry to the next
	task automatic apply_entry(input int i);
		logic latched;
		address_req = t_addr[i];
		we = t_we[i];
		data_w = t_data[i];
		do_act = 1'b1;
		latched = 1'b0;
		while (!latched)
		begin
			#2;  // command_latched settles well before the rising edge
			latched = command_latched;
			if (!latched)
				@(negedge CLK);
		end
		if (t_kind[i] == KIND_HIT && n_arsr == snap_arsr)
			check_value({t_name[i], "_no_actv"}, snap_actv, n_actv);
		if (t_kind[i] == KIND_MISS)
			check_value({t_name[i], "_prch_actv"}, 32'd1,
				word_t'(n_prch > snap_prch && n_actv > snap_actv));
		snap_actv = n_actv;
		snap_prch = n_prch;
		snap_arsr = n_arsr;
		if (t_we[i])
			shadow[t_addr[i]] = t_data[i];
		else
		begin
			exp_q.push_back(shadow[t_addr[i]]);
			exp_name.push_back(t_name[i]);
		end
		@(negedge CLK);
	endtask

	// command counts, refresh spacing and read data on the falling edge
	always @(negedge CLK)
	begin
		if (RST)
		begin
			since_arsr++;
			case (cmd)
				ACTV: n_actv++;
				PRCH: n_prch++;
				ARSR:
				begin
					n_arsr++;
					since_arsr = 0;
				end
				default: ;
			endcase
			if (since_arsr > REFRESH_LIMIT)
			begin
				report_failure($sformatf("no ARSR within %0d cycles", REFRESH_LIMIT));
				since_arsr = 0;
			end
			if (data_r_valid)
			begin
				if (exp_q.size() == 0)
					report_failure("data_r_valid pulsed with no read outstanding");
				else
					check_value(exp_name.pop_front(), exp_q.pop_front(), data_r);
			end
		end
	end

	initial
	begin
		void'($urandom(32'h62b75a8f));
		RST = 1'b0;
		do_act = 1'b0;
		we = 1'b0;
		address_req = '0;
		data_w = '0;
		fill_table();
		repeat (10) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);
		check_value("reset_cmd", word_t'(NOOP), word_t'(cmd));
		check_value("reset_dm", 32'd1, word_t'(dm));
		check_value("reset_dqs", 32'd0, word_t'(dqs));
		check_value("reset_valid", 32'd0, word_t'(data_r_valid));
		for (int i = 0; i < NUM_ENTRIES; i++)
			apply_entry(i);
		do_act = 1'b0;
		while (exp_q.size() != 0)
			@(negedge CLK);
		repeat (2 * REFRESH_PERIOD) @(negedge CLK);  // idle stretch with refresh only
		if (n_arsr == 0)
			report_failure("no ARSR seen during the whole run");
		$display("errors: %0d testbench, %0d model", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_model import sdram_pkg::*; #(
	parameter int CAS_LATENCY = 2
) (
	input  wire           CLK,
	input  wire           RST,
	input  var cmd_t      cmd,
	input  var pin_addr_t pin_addr,
	input  var bank_t     bank,
	inout  wire beat_t    dq,
	input  wire           dm,
	input  wire           dqs,
	output int            errors
);

	typedef logic [26:0] key_t;  // {bank, row, col, half}

	beat_t mem [key_t];
	logic [3:0] bank_open;
	row_t  open_row [4];
	cmd_t  last_cmd;      // last non-NOOP command
	int    last_cyc;
	int    cyc;
	logic  wr_v0;         // high write beat on dq this edge
	logic  wr_v1;         // low write beat on dq this edge
	key_t  wr_k0;
	key_t  wr_k1;
	int    rd_time [$];   // cycle at which a read beat goes out
	key_t  rd_key [$];
	logic  drv_en;
	beat_t drv_val;

	assign dq = drv_en ? drv_val : 'z;

	initial errors = 0;

	function automatic int min_gap(input cmd_t c);
		case (c)
			ARSR: return 13;
			ACTV: return 4;
			READ: return 4;
			default: return 5;  // WRTE and PRCH
		endcase
	endfunction

	function automatic beat_t read_beat(input key_t k);
		if (mem.exists(k))
			return mem[k];
		return k[15:0] ^ {5'b0, k[26:16]};  // fill for locations never written
	endfunction

	task automatic violation(input string what);
		$display("model: %s at %0t", what, $time);
		errors++;
	endtask

	task automatic check_command();
		if (last_cmd != NOOP && cmd != last_cmd && (cyc - last_cyc) < min_gap(last_cmd))
			violation($sformatf("%s only %0d cycles after %s", cmd.name(),
				cyc - last_cyc, last_cmd.name()));
		case (cmd)
			ACTV:
			begin
				if (bank_open[bank])
					violation("ACTV to a bank whose row is still open");
				bank_open[bank] <= 1'b1;
				open_row[bank] <= {pin_addr[12:11], pin_addr[9:0]};  // a10 is not a row bit
			end
			READ, WRTE:
				if (!bank_open[bank])
					violation("READ or WRTE to a bank with no open row");
			PRCH:
				if (pin_addr[10])
					bank_open <= '0;
				else
					bank_open[bank] <= 1'b0;
			ARSR:
				if (|bank_open)
					violation("ARSR issued while a row is open");
			default:
				violation("illegal command code on cmd");
		endcase
		last_cmd <= cmd;
		last_cyc <= cyc;
	endtask

	always @(posedge CLK)
	begin
		if (!RST)
		begin
			cyc <= 0;
			last_cmd <= NOOP;
			bank_open <= '0;
			wr_v0 <= 1'b0;
			wr_v1 <= 1'b0;
			drv_en <= 1'b0;
		end
		else
		begin
			cyc <= cyc + 1;
			if (wr_v0 || wr_v1)
			begin
				if (dm !== 1'b0 || dqs !== 1'b1)
					violation("write beat without dm low and dqs high");
			end
			else if (dqs !== 1'b0)
				violation("dqs high outside a write burst");
			if (wr_v0)
				mem[wr_k0] = dq;
			if (wr_v1)
				mem[wr_k1] = dq;
			wr_v1 <= wr_v0;
			wr_k1 <= {wr_k0[26:1], 1'b1};
			wr_v0 <= (cmd == WRTE);
			wr_k0 <= {bank, open_row[bank], pin_addr[12:1], 1'b0};
			if (cmd == READ)
			begin
				rd_time.push_back(cyc + CAS_LATENCY - 1);  // high half first
				rd_key.push_back({bank, open_row[bank], pin_addr[12:1], 1'b0});
				rd_time.push_back(cyc + CAS_LATENCY);
				rd_key.push_back({bank, open_row[bank], pin_addr[12:1], 1'b1});
			end
			if (rd_time.size() > 0 && rd_time[0] == cyc)
			begin
				drv_en <= 1'b1;
				drv_val <= read_beat(rd_key.pop_front());
				void'(rd_time.pop_front());
			end
			else
				drv_en <= 1'b0;
			if (cmd != NOOP)
				check_command();
		end
	end

endmodule

`default_nettype wire
